// File: hdl/fftPkg.sv
package fftPkg;

    localparam int FFT_POINTS     = 32;
    localparam int ADDR_W         = 5;
    localparam int STAGES         = 5;
    localparam int DATA_W         = 16;
    localparam int TW_FRAC        = 14;  // q1.14 so +1.0 is stored as 16384
    localparam int BFLY_LAT       = 3;
    localparam int IN_CREDITS     = 32;
    localparam int OUT_CREDIT_MAX = 8;   // most output credits the consumer may hand out

    localparam int IN_CNT_W       = $clog2(IN_CREDITS + 1);
    localparam int OUT_CNT_W      = $clog2(OUT_CREDIT_MAX + 1);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        COMPUTE,
        DRAIN,     // waits for the last butterfly writes of a stage
        UNLOAD
    } ctrlState_t;

    // source of bank 0 port A
    typedef enum logic {
        SEL_LOAD,
        SEL_BFLY
    } busSel_t;

endpackage

// File: hdl/fftBankRam.sv
`timescale 1ns/1ps

module fftBankRam (
    input  logic                              clock_i,
    input  logic                              aEn_i,
    input  logic                              bEn_i,
    input  logic        [fftPkg::ADDR_W-1:0]  aAddr_i,
    input  logic        [fftPkg::ADDR_W-1:0]  bAddr_i,
    input  logic signed [fftPkg::DATA_W-1:0]  aDataRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  aDataIm_i,
    input  logic signed [fftPkg::DATA_W-1:0]  bDataRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  bDataIm_i,
    output logic signed [fftPkg::DATA_W-1:0]  aOutRe_o,
    output logic signed [fftPkg::DATA_W-1:0]  aOutIm_o,
    output logic signed [fftPkg::DATA_W-1:0]  bOutRe_o,
    output logic signed [fftPkg::DATA_W-1:0]  bOutIm_o
);
    import fftPkg::*;

    logic signed [DATA_W-1:0] memRe [FFT_POINTS];
    logic signed [DATA_W-1:0] memIm [FFT_POINTS];

    // a port writes when enabled and reads otherwise
    always_ff @(posedge clock_i) begin
        if (aEn_i) begin
            memRe[aAddr_i] <= aDataRe_i;
            memIm[aAddr_i] <= aDataIm_i;
        end else begin
            aOutRe_o <= memRe[aAddr_i];
            aOutIm_o <= memIm[aAddr_i];
        end
        if (bEn_i) begin
            memRe[bAddr_i] <= bDataRe_i;  // the two ports never write the same word
            memIm[bAddr_i] <= bDataIm_i;
        end else begin
            bOutRe_o <= memRe[bAddr_i];
            bOutIm_o <= memIm[bAddr_i];
        end
    end

endmodule

// File: hdl/fftDataMem.sv
`timescale 1ns/1ps

module fftDataMem (
    input  logic                              clock_i,
    input  logic                              loadWrite_i,
    input  fftPkg::busSel_t                   busSel_i,
    input  logic                              bank0WriteEn_i,
    input  logic                              bank1WriteEn_i,
    input  logic                              rwAddrSel_i,    // 1 while bank 0 is the read bank
    input  logic                              bankReadSel_i,
    input  logic        [fftPkg::ADDR_W-1:0]  loadAddr_i,
    input  logic        [fftPkg::ADDR_W-1:0]  readGAddr_i,
    input  logic        [fftPkg::ADDR_W-1:0]  readHAddr_i,
    input  logic        [fftPkg::ADDR_W-1:0]  writeGAddr_i,
    input  logic        [fftPkg::ADDR_W-1:0]  writeHAddr_i,
    input  logic signed [fftPkg::DATA_W-1:0]  loadRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  loadIm_i,
    input  logic signed [fftPkg::DATA_W-1:0]  xRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  xIm_i,
    input  logic signed [fftPkg::DATA_W-1:0]  yRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  yIm_i,
    output logic signed [fftPkg::DATA_W-1:0]  gRe_o,
    output logic signed [fftPkg::DATA_W-1:0]  gIm_o,
    output logic signed [fftPkg::DATA_W-1:0]  hRe_o,
    output logic signed [fftPkg::DATA_W-1:0]  hIm_o
);
    import fftPkg::*;

    logic                     a0En, b0En, b1En;
    logic [ADDR_W-1:0]        a0Addr, b0Addr, a1Addr, b1Addr;
    logic signed [DATA_W-1:0] a0Re, a0Im, xRe, xIm, yRe, yIm;
    logic signed [DATA_W-1:0] g0Re, g0Im, h0Re, h0Im;
    logic signed [DATA_W-1:0] g1Re, g1Im, h1Re, h1Im;

    // controls settle half a cycle before the RAM edge
    always_ff @(negedge clock_i) begin
        if (busSel_i == SEL_LOAD) begin
            a0En   <= loadWrite_i;
            a0Addr <= loadAddr_i;
            a0Re   <= loadRe_i;
            a0Im   <= loadIm_i;
        end else begin
            a0En   <= bank0WriteEn_i;
            a0Addr <= rwAddrSel_i ? readGAddr_i : writeGAddr_i;
            a0Re   <= xRe_i;
            a0Im   <= xIm_i;
        end
        b0En   <= bank0WriteEn_i;
        b1En   <= bank1WriteEn_i;
        b0Addr <= rwAddrSel_i ? readHAddr_i : writeHAddr_i;
        a1Addr <= rwAddrSel_i ? writeGAddr_i : readGAddr_i;
        b1Addr <= rwAddrSel_i ? writeHAddr_i : readHAddr_i;
        xRe    <= xRe_i;
        xIm    <= xIm_i;
        yRe    <= yRe_i;
        yIm    <= yIm_i;
    end

    fftBankRam bank0 (
        .clock_i(clock_i),     .aEn_i(a0En),         .bEn_i(b0En),
        .aAddr_i(a0Addr),      .bAddr_i(b0Addr),
        .aDataRe_i(a0Re),      .aDataIm_i(a0Im),     .bDataRe_i(yRe),   .bDataIm_i(yIm),
        .aOutRe_o(g0Re),       .aOutIm_o(g0Im),      .bOutRe_o(h0Re),   .bOutIm_o(h0Im)
    );

    fftBankRam bank1 (
        .clock_i(clock_i),     .aEn_i(b1En),         .bEn_i(b1En),
        .aAddr_i(a1Addr),      .bAddr_i(b1Addr),
        .aDataRe_i(xRe),       .aDataIm_i(xIm),      .bDataRe_i(yRe),   .bDataIm_i(yIm),
        .aOutRe_o(g1Re),       .aOutIm_o(g1Im),      .bOutRe_o(h1Re),   .bOutIm_o(h1Im)
    );

    assign gRe_o = bankReadSel_i ? g1Re : g0Re;
    assign gIm_o = bankReadSel_i ? g1Im : g0Im;
    assign hRe_o = bankReadSel_i ? h1Re : h0Re;
    assign hIm_o = bankReadSel_i ? h1Im : h0Im;

endmodule

// File: hdl/fftButterfly.sv
`timescale 1ns/1ps

module fftButterfly (
    input  logic                              clock_i,
    input  logic                              rstN_i,
    input  logic                              valid_i,
    input  logic signed [fftPkg::DATA_W-1:0]  gRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  gIm_i,
    input  logic signed [fftPkg::DATA_W-1:0]  hRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  hIm_i,
    input  logic signed [fftPkg::DATA_W-1:0]  twRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  twIm_i,
    output logic                              valid_o,
    output logic signed [fftPkg::DATA_W-1:0]  xRe_o,
    output logic signed [fftPkg::DATA_W-1:0]  xIm_o,
    output logic signed [fftPkg::DATA_W-1:0]  yRe_o,
    output logic signed [fftPkg::DATA_W-1:0]  yIm_o
);
    import fftPkg::*;

    logic [BFLY_LAT-1:0]      validPipe;
    logic signed [2*DATA_W-1:0] pRR, pII, pRI, pIR;
    logic signed [2*DATA_W:0]   prodRe, prodIm, scaledRe, scaledIm;
    logic signed [DATA_W+1:0]   mRe, mIm;      // h times twiddle, back in data scale
    logic signed [DATA_W-1:0]   g1Re, g1Im, g2Re, g2Im;
    logic signed [DATA_W+2:0]   xSumRe, xSumIm, ySumRe, ySumIm;

    always_ff @(posedge clock_i or negedge rstN_i) begin
        if (!rstN_i) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[BFLY_LAT-2:0], valid_i};
        end
    end
    assign valid_o = validPipe[BFLY_LAT-1];

    assign prodRe   = pRR - pII;
    assign prodIm   = pRI + pIR;
    assign scaledRe = prodRe >>> TW_FRAC;
    assign scaledIm = prodIm >>> TW_FRAC;
    assign xSumRe   = g2Re + mRe;
    assign xSumIm   = g2Im + mIm;
    assign ySumRe   = g2Re - mRe;
    assign ySumIm   = g2Im - mIm;

    always_ff @(posedge clock_i) begin
        pRR   <= hRe_i * twRe_i;
        pII   <= hIm_i * twIm_i;
        pRI   <= hRe_i * twIm_i;
        pIR   <= hIm_i * twRe_i;
        g1Re  <= gRe_i;
        g1Im  <= gIm_i;
        mRe   <= scaledRe[DATA_W+1:0];
        mIm   <= scaledIm[DATA_W+1:0];
        g2Re  <= g1Re;
        g2Im  <= g1Im;
        xRe_o <= xSumRe[DATA_W:1];  // every stage halves so the frame ends scaled by 1/32
        xIm_o <= xSumIm[DATA_W:1];
        yRe_o <= ySumRe[DATA_W:1];
        yIm_o <= ySumIm[DATA_W:1];
    end

endmodule

// File: hdl/fftTwiddleRom.sv
`timescale 1ns/1ps

module fftTwiddleRom (
    input  logic                              clock_i,
    input  logic        [fftPkg::ADDR_W-2:0]  twIdx_i,
    output logic signed [fftPkg::DATA_W-1:0]  twRe_o,
    output logic signed [fftPkg::DATA_W-1:0]  twIm_o
);
    import fftPkg::*;

    logic [2*DATA_W-1:0] tw;  // cos in the upper half, -sin in the lower

    always_ff @(posedge clock_i) begin
        case (twIdx_i)
            4'd0:    tw <= {16'sd16384,  16'sd0};
            4'd1:    tw <= {16'sd16069, -16'sd3196};
            4'd2:    tw <= {16'sd15137, -16'sd6270};
            4'd3:    tw <= {16'sd13623, -16'sd9102};
            4'd4:    tw <= {16'sd11585, -16'sd11585};
            4'd5:    tw <= {16'sd9102,  -16'sd13623};
            4'd6:    tw <= {16'sd6270,  -16'sd15137};
            4'd7:    tw <= {16'sd3196,  -16'sd16069};
            4'd8:    tw <= {16'sd0,     -16'sd16384};
            4'd9:    tw <= {-16'sd3196,  -16'sd16069};
            4'd10:   tw <= {-16'sd6270,  -16'sd15137};
            4'd11:   tw <= {-16'sd9102,  -16'sd13623};
            4'd12:   tw <= {-16'sd11585, -16'sd11585};
            4'd13:   tw <= {-16'sd13623, -16'sd9102};
            4'd14:   tw <= {-16'sd15137, -16'sd6270};
            default: tw <= {-16'sd16069, -16'sd3196};
        endcase
    end

    assign twRe_o = tw[2*DATA_W-1:DATA_W];
    assign twIm_o = tw[DATA_W-1:0];

endmodule

// File: hdl/fftController.sv
`timescale 1ns/1ps

module fftController (
    input  logic                        clock_i,
    input  logic                        rstN_i,
    input  logic                        inValid_i,
    input  logic                        outCredit_i,
    output logic                        inCredit_o,
    output logic                        outValid_o,
    output logic [fftPkg::ADDR_W-1:0]   outIdx_o,
    output logic                        loadWrite_o,
    output fftPkg::busSel_t             busSel_o,
    output logic                        bank0WriteEn_o,
    output logic                        bank1WriteEn_o,
    output logic                        rwAddrSel_o,
    output logic                        bankReadSel_o,
    output logic [fftPkg::ADDR_W-1:0]   loadAddr_o,
    output logic [fftPkg::ADDR_W-1:0]   readGAddr_o,
    output logic [fftPkg::ADDR_W-1:0]   readHAddr_o,
    output logic [fftPkg::ADDR_W-1:0]   writeGAddr_o,
    output logic [fftPkg::ADDR_W-1:0]   writeHAddr_o,
    output logic [fftPkg::ADDR_W-2:0]   twIdx_o,
    output logic                        bflyValid_o,
    input  logic                        bflyValid_i
);
    import fftPkg::*;

    ctrlState_t           state;
    logic [IN_CNT_W-1:0]  creditCnt;   // input credits issued for the coming frame
    logic [IN_CNT_W-1:0]  loadCnt;
    logic [OUT_CNT_W-1:0] outCredits;
    logic [ADDR_W-2:0]    bflyCnt;
    logic [2:0]           stage;
    logic [2:0]           drainCnt;
    logic [ADDR_W-1:0]    unloadCnt;
    logic                 primed;      // read data for unloadCnt is on the G port
    logic                 loadPhase, computePhase;
    logic [ADDR_W-1:0]    kExt, span, mask, pairG;
    logic [ADDR_W-1:0]    gPipe [BFLY_LAT+1];
    logic [ADDR_W-1:0]    hPipe [BFLY_LAT+1];

    assign loadPhase    = (state == LOAD) || (state == UNLOAD);  // bank 0 is free in both
    assign computePhase = (state == COMPUTE) || (state == DRAIN);

    assign inCredit_o  = loadPhase && (creditCnt != IN_CNT_W'(IN_CREDITS));
    assign loadWrite_o = loadPhase && inValid_i;
    always_comb begin
        for (int i = 0; i < ADDR_W; i++) begin
            loadAddr_o[i] = loadCnt[ADDR_W-1-i];
        end
    end

    // stage s pairs words 2^s apart
    assign kExt    = {1'b0, bflyCnt};
    assign span    = ADDR_W'(1) << stage;
    assign mask    = span - 1'b1;
    assign pairG   = ((kExt & ~mask) << 1) | (kExt & mask);
    assign twIdx_o = (bflyCnt & mask[ADDR_W-2:0]) << (3'(STAGES - 1) - stage);

    assign outValid_o = (state == UNLOAD) && primed && (outCredits != '0);
    assign outIdx_o   = unloadCnt;

    always_comb begin
        if (state == UNLOAD) begin
            readGAddr_o = outValid_o ? unloadCnt + 1'b1 : unloadCnt;  // look ahead when one leaves
            readHAddr_o = unloadCnt;
        end else begin
            readGAddr_o = pairG;
            readHAddr_o = pairG | span;
        end
    end

    assign busSel_o       = computePhase ? SEL_BFLY : SEL_LOAD;
    assign rwAddrSel_o    = computePhase && !stage[0];
    assign bankReadSel_o  = (state == UNLOAD) || stage[0];
    assign bank0WriteEn_o = bflyValid_i && stage[0];
    assign bank1WriteEn_o = bflyValid_i && !stage[0];

    // write addresses trail the reads by the RAM read cycle plus the butterfly
    always_ff @(posedge clock_i) begin
        gPipe[0] <= pairG;
        hPipe[0] <= pairG | span;
        for (int i = 1; i <= BFLY_LAT; i++) begin
            gPipe[i] <= gPipe[i-1];
            hPipe[i] <= hPipe[i-1];
        end
    end
    assign writeGAddr_o = gPipe[BFLY_LAT];
    assign writeHAddr_o = hPipe[BFLY_LAT];

    always_ff @(posedge clock_i or negedge rstN_i) begin
        if (!rstN_i) begin
            state       <= IDLE;
            creditCnt   <= '0;
            loadCnt     <= '0;
            outCredits  <= '0;
            bflyCnt     <= '0;
            stage       <= '0;
            drainCnt    <= '0;
            unloadCnt   <= '0;
            primed      <= 1'b0;
            bflyValid_o <= 1'b0;
        end else begin
            bflyValid_o <= (state == COMPUTE);  // lines up with G/H read data
            outCredits  <= outCredits + outCredit_i - outValid_o;
            if (inCredit_o) begin
                creditCnt <= creditCnt + 1'b1;
            end
            if (loadWrite_o) begin
                loadCnt <= loadCnt + 1'b1;
            end
            case (state)
                IDLE: state <= LOAD;
                LOAD: begin
                    if (loadCnt == IN_CNT_W'(FFT_POINTS)) begin
                        state     <= COMPUTE;
                        creditCnt <= '0;
                        loadCnt   <= '0;
                        stage     <= '0;
                        bflyCnt   <= '0;
                    end
                end
                COMPUTE: begin
                    bflyCnt <= bflyCnt + 1'b1;
                    if (&bflyCnt) begin
                        state    <= DRAIN;
                        drainCnt <= '0;
                    end
                end
                DRAIN: begin
                    drainCnt <= drainCnt + 1'b1;
                    if (drainCnt == 3'(BFLY_LAT + 1)) begin
                        if (stage == 3'(STAGES - 1)) begin
                            state     <= UNLOAD;
                            unloadCnt <= '0;
                            primed    <= 1'b0;
                        end else begin
                            state <= COMPUTE;
                            stage <= stage + 1'b1;
                        end
                    end
                end
                UNLOAD: begin
                    primed <= 1'b1;
                    if (outValid_o) begin
                        unloadCnt <= unloadCnt + 1'b1;
                        if (&unloadCnt) begin
                            state <= LOAD;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hdl/fftTop.sv
`timescale 1ns/1ps

module fftTop (
    input  logic                              clock_i,
    input  logic                              rstN_i,
    input  logic                              inValid_i,
    input  logic signed [fftPkg::DATA_W-1:0]  inRe_i,
    input  logic signed [fftPkg::DATA_W-1:0]  inIm_i,
    input  logic                              outCredit_i,
    output logic                              inCredit_o,
    output logic                              outValid_o,
    output logic        [fftPkg::ADDR_W-1:0]  outIdx_o,
    output logic signed [fftPkg::DATA_W-1:0]  outRe_o,
    output logic signed [fftPkg::DATA_W-1:0]  outIm_o
);
    import fftPkg::*;

    logic                     loadWrite, bank0WriteEn, bank1WriteEn, rwAddrSel, bankReadSel;
    busSel_t                  busSel;
    logic [ADDR_W-1:0]        loadAddr, readGAddr, readHAddr, writeGAddr, writeHAddr;
    logic [ADDR_W-2:0]        twIdx;
    logic                     bflyValidIn, bflyValidOut;
    logic signed [DATA_W-1:0] hRe, hIm, twRe, twIm;
    logic signed [DATA_W-1:0] xRe, xIm, yRe, yIm;

    fftController fftController_inst (
        .clock_i(clock_i),             .rstN_i(rstN_i),
        .inValid_i(inValid_i),         .outCredit_i(outCredit_i),
        .inCredit_o(inCredit_o),       .outValid_o(outValid_o),     .outIdx_o(outIdx_o),
        .loadWrite_o(loadWrite),       .busSel_o(busSel),
        .bank0WriteEn_o(bank0WriteEn), .bank1WriteEn_o(bank1WriteEn),
        .rwAddrSel_o(rwAddrSel),       .bankReadSel_o(bankReadSel),
        .loadAddr_o(loadAddr),         .readGAddr_o(readGAddr),     .readHAddr_o(readHAddr),
        .writeGAddr_o(writeGAddr),     .writeHAddr_o(writeHAddr),
        .twIdx_o(twIdx),               .bflyValid_o(bflyValidIn),   .bflyValid_i(bflyValidOut)
    );

    // the unload stream leaves on the G port of bank 1
    fftDataMem fftDataMem_inst (
        .clock_i(clock_i),             .loadWrite_i(loadWrite),     .busSel_i(busSel),
        .bank0WriteEn_i(bank0WriteEn), .bank1WriteEn_i(bank1WriteEn),
        .rwAddrSel_i(rwAddrSel),       .bankReadSel_i(bankReadSel),
        .loadAddr_i(loadAddr),         .readGAddr_i(readGAddr),     .readHAddr_i(readHAddr),
        .writeGAddr_i(writeGAddr),     .writeHAddr_i(writeHAddr),
        .loadRe_i(inRe_i),             .loadIm_i(inIm_i),
        .xRe_i(xRe),                   .xIm_i(xIm),                 .yRe_i(yRe),   .yIm_i(yIm),
        .gRe_o(outRe_o),               .gIm_o(outIm_o),             .hRe_o(hRe),   .hIm_o(hIm)
    );

    fftButterfly fftButterfly_inst (
        .clock_i(clock_i),             .rstN_i(rstN_i),             .valid_i(bflyValidIn),
        .gRe_i(outRe_o),               .gIm_i(outIm_o),             .hRe_i(hRe),   .hIm_i(hIm),
        .twRe_i(twRe),                 .twIm_i(twIm),               .valid_o(bflyValidOut),
        .xRe_o(xRe),                   .xIm_o(xIm),                 .yRe_o(yRe),   .yIm_o(yIm)
    );

    fftTwiddleRom fftTwiddleRom_inst (
        .clock_i(clock_i),
        .twIdx_i(twIdx),
        .twRe_o(twRe),
        .twIm_o(twIm)
    );

endmodule

// File: bench/fftTop_assertions.sv
`timescale 1ns/1ps

module fftTop_assertions (
    input logic clock_i,
    input logic rstN_i,
    input logic inValid_i,
    input logic inCredit_i,
    input logic outCredit_i,
    input logic outValid_i
);
    import fftPkg::*;

    int issuedIn;  // input credits granted since reset
    int takenIn;   // samples accepted since reset
    int heldOut;   // output credits handed in by the consumer

    always_ff @(posedge clock_i or negedge rstN_i) begin
        if (!rstN_i) begin
            issuedIn <= 0;
            takenIn  <= 0;
            heldOut  <= 0;
        end else begin
            issuedIn <= issuedIn + int'(inCredit_i);
            takenIn  <= takenIn + int'(inValid_i);
            heldOut  <= heldOut + int'(outCredit_i) - int'(outValid_i);
        end
    end

    outNeedsCredit: assert property (@(posedge clock_i) disable iff (!rstN_i)
        outValid_i |-> heldOut > 0)
        else $error("outValid_o high with no output credit held");

    // credits for the next frame only follow a complete frame of samples
    inCreditLimit: assert property (@(posedge clock_i) disable iff (!rstN_i)
        inCredit_i |-> issuedIn < IN_CREDITS * (takenIn / FFT_POINTS + 1))
        else $error("more than one frame of input credits issued");

    quietInReset: assert property (@(posedge clock_i) !rstN_i |-> !inCredit_i && !outValid_i)
        else $error("credit or valid output active during reset");

    quietAfterReset: assert property (@(posedge clock_i) $rose(rstN_i) |-> !inCredit_i && !outValid_i)
        else $error("credit or valid output active right after reset");

endmodule

bind fftTop fftTop_assertions fftTop_assertions_inst (
    .clock_i(clock_i),         .rstN_i(rstN_i),         .inValid_i(inValid_i),
    .inCredit_i(inCredit_o),   .outCredit_i(outCredit_i), .outValid_i(outValid_o)
);

// File: bench/fftTb.sv
`timescale 1ns/1ps

module fftTb;
    import fftPkg::*;

    localparam int  NUM_ROWS    = 6;
    localparam int  NUM_OUT     = NUM_ROWS * FFT_POINTS;
    localparam int  FRAME_BOUND = FFT_POINTS + STAGES * (FFT_POINTS / 2 + BFLY_LAT + 3)
                                  + 4 * FFT_POINTS + 16;
    localparam int  CYCLE_LIMIT = 40 * FRAME_BOUND;
    localparam int  IMPULSE = 0, DC = 1, TONE = 2, RANDOM = 3;
    localparam real TOL = 3.0;
    localparam real PI  = 3.14159265358979;

    // one frame per row, sent back to back
    int rowKind  [NUM_ROWS] = '{IMPULSE, DC, TONE, RANDOM, RANDOM, RANDOM};
    int rowAmp   [NUM_ROWS] = '{3200, 1600, 8000, 4000, 4000, 4000};
    int rowBin   [NUM_ROWS] = '{0, 0, 3, 0, 0, 0};
    bit rowStall [NUM_ROWS] = '{0, 0, 0, 0, 1, 1};  // stalled rows get random credit gaps

    logic                     clock, rstN, inValid, outCredit, inCredit, outValid;
    logic signed [DATA_W-1:0] inRe, inIm, outRe, outIm;
    logic [ADDR_W-1:0]        outIdx;

    int  sampleRe [NUM_OUT];
    int  sampleIm [NUM_OUT];
    real expRe [NUM_OUT];
    real expIm [NUM_OUT];
    int  sent, sendLimit, received, heldIn, heldOut, creditsSeen, cycleCnt;
    int  errors, frameErrors, good;

    fftTop fftTop_inst (
        .clock_i(clock),         .rstN_i(rstN),         .inValid_i(inValid),
        .inRe_i(inRe),           .inIm_i(inIm),         .outCredit_i(outCredit),
        .inCredit_o(inCredit),   .outValid_o(outValid), .outIdx_o(outIdx),
        .outRe_o(outRe),         .outIm_o(outIm)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        cycleCnt = 0;
        while (cycleCnt < CYCLE_LIMIT) begin
            @(posedge clock);
            cycleCnt++;
        end
        $display("run stopped after %0d cycles with %0d of %0d results received",
                 cycleCnt, received, NUM_OUT);
        $display("Test failed");
        $finish;
    end

    function automatic string kindName(input int kind);
        case (kind)
            IMPULSE: return "impulse";
            DC:      return "dc";
            TONE:    return "tone";
            default: return "random";
        endcase
    endfunction

    task automatic makeFrame(input int row);
        int base;
        base = row * FFT_POINTS;
        for (int n = 0; n < FFT_POINTS; n++) begin
            case (rowKind[row])
                IMPULSE: sampleRe[base+n] = (n == 0) ? rowAmp[row] : 0;
                DC:      sampleRe[base+n] = rowAmp[row];
                TONE:    sampleRe[base+n] = int'(rowAmp[row]
                                                * $cos(2.0 * PI * rowBin[row] * n / FFT_POINTS));
                default: sampleRe[base+n] = int'($urandom % (2 * rowAmp[row] - 1))
                                            - (rowAmp[row] - 1);
            endcase
            sampleIm[base+n] = 0;
            if (rowKind[row] == RANDOM) begin
                sampleIm[base+n] = int'($urandom % (2 * rowAmp[row] - 1)) - (rowAmp[row] - 1);
            end
        end
    endtask

    // plain DFT of the frame, divided by the point count
    task automatic referenceDft(input int row);
        int  base;
        real accRe, accIm, ang;
        base = row * FFT_POINTS;
        for (int k = 0; k < FFT_POINTS; k++) begin
            accRe = 0.0;
            accIm = 0.0;
            for (int n = 0; n < FFT_POINTS; n++) begin
                ang   = 2.0 * PI * k * n / FFT_POINTS;
                accRe += sampleRe[base+n] * $cos(ang) + sampleIm[base+n] * $sin(ang);
                accIm += sampleIm[base+n] * $cos(ang) - sampleRe[base+n] * $sin(ang);
            end
            expRe[base+k] = accRe / FFT_POINTS;
            expIm[base+k] = accIm / FFT_POINTS;
        end
    endtask

    task automatic checkResult();
        int  frame, bin, gotRe, gotIm;
        real dRe, dIm;
        frame = received / FFT_POINTS;
        bin   = received % FFT_POINTS;
        gotRe = outRe;
        gotIm = outIm;
        dRe   = gotRe - expRe[received];
        dIm   = gotIm - expIm[received];
        if (heldOut == 0) begin
            $display("result %0d came out while no output credit was held", received);
            frameErrors++;
        end
        if (outIdx != bin) begin
            $display("ERROR at %0t: frame %0d index %0d, expected %0d", $time, frame, outIdx, bin);
            frameErrors++;
        end
        if (dRe > TOL || dRe < -TOL || dIm > TOL || dIm < -TOL) begin
            $display("ERROR at %0t: frame %0d bin %0d got (%0d, %0d), expected (%.2f, %.2f)",
                     $time, frame, bin, gotRe, gotIm, expRe[received], expIm[received]);
            frameErrors++;
        end
        heldOut--;
        received++;
        if (bin == FFT_POINTS - 1) begin
            if (creditsSeen != IN_CREDITS * (frame + 2)) begin
                $display("frame %0d saw %0d input credits in total, expected %0d",
                         frame, creditsSeen, IN_CREDITS * (frame + 2));
                frameErrors++;
            end
            $display("test %0d: %s amp %0d, %s output credits, %0d mismatches", frame + 1,
                     kindName(rowKind[frame]), rowAmp[frame],
                     rowStall[frame] ? "stalled" : "free", frameErrors);
            good   += (frameErrors == 0);
            errors += frameErrors;
            frameErrors = 0;
        end
    endtask

    // drive on the rising edge, sample on the falling edge
    task automatic runCycle();
        bit grant;
        @(posedge clock);
        if (heldIn > 0 && sent < sendLimit) begin
            inValid <= 1'b1;
            inRe    <= DATA_W'(sampleRe[sent]);
            inIm    <= DATA_W'(sampleIm[sent]);
            heldIn--;
            sent++;
        end else begin
            inValid <= 1'b0;
        end
        grant = heldOut < OUT_CREDIT_MAX;
        if (received < NUM_OUT && rowStall[received / FFT_POINTS] && ($urandom % 4) != 0) begin
            grant = 1'b0;
        end
        outCredit <= grant;
        @(negedge clock);
        if (inCredit) begin
            heldIn++;
            creditsSeen++;
        end
        if (outValid) begin
            checkResult();
        end
        heldOut += grant;  // a credit counts once its pulse has ended
    endtask

    initial begin
        void'($urandom(32'h9b00410d));
        rstN        = 1'b0;
        inValid     = 1'b0;
        inRe        = '0;
        inIm        = '0;
        outCredit   = 1'b0;
        sent        = 0;
        sendLimit   = 0;
        received    = 0;
        heldIn      = 0;
        heldOut     = 0;
        creditsSeen = 0;
        errors      = 0;
        frameErrors = 0;
        good        = 0;
        repeat (10) @(posedge clock);
        rstN <= 1'b1;
        for (int i = 0; i < 2 * FFT_POINTS; i++) begin
            runCycle();
        end
        if (creditsSeen != IN_CREDITS || received != 0) begin
            $display("idle start gave %0d input credits and %0d results, expected %0d and 0",
                     creditsSeen, received, IN_CREDITS);
            frameErrors++;
        end
        $display("test 0: idle after reset, %0d mismatches", frameErrors);
        good  += (frameErrors == 0);
        errors += frameErrors;
        frameErrors = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            makeFrame(r);
            referenceDft(r);
        end
        sendLimit = NUM_OUT;
        while (received < NUM_OUT) begin
            runCycle();
        end
        $display("tests run %0d, good %0d, bad %0d, errors %0d",
                 NUM_ROWS + 1, good, NUM_ROWS + 1 - good, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/fftPkg.sv
hdl/fftBankRam.sv
hdl/fftDataMem.sv
hdl/fftButterfly.sv
hdl/fftTwiddleRom.sv
hdl/fftController.sv
hdl/fftTop.sv
bench/fftTop_assertions.sv
bench/fftTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fftTb -f build.f -o fftSim || exit 1
out=$(./obj_dir/fftSim)
echo "$out"
echo "$out" | grep -q "^Test completed successfully$" && exit 0 || exit 1
